// ==== logic/sync_cfg_pkg.sv ====
// clocking and NCO configuration for the ADXL355 sync generator
// accumulator and counter widths, top-level parameter defaults
package sync_cfg_pkg;

  // phase accumulator
  localparam int unsigned phase_w = 32;         // NCO accumulator width
  typedef logic [phase_w-1:0] phase_t;          // phase increment word

  // clock-cycle counters between PPS edges
  localparam int unsigned interval_cnt_w = 32;

  // defaults for the top level
  localparam int unsigned default_clk_hz    = 40_000_000; // system clock
  localparam int unsigned default_sync_hz   = 1_000;      // sensor sample rate
  localparam int unsigned default_pps_n     = 1;          // pulses per interval
  localparam int unsigned default_pps_s     = 1;          // interval length, seconds
  localparam int unsigned default_tol_us    = 500;        // +- edge tolerance
  localparam int unsigned default_corr_step = 2;          // increment step per correction

endpackage

// ==== logic/sync_stat_pkg.sv ====
// status definitions for the ADXL355 sync generator
// PPS monitor status and the SYNC pulse count shown on the LEDs
package sync_stat_pkg;

  localparam int unsigned count_w = 8;     // LED counter width
  typedef logic [count_w-1:0] sync_count_t;

  // monitor result, edge strobe plus validity level
  typedef struct packed {
    logic pps_edge;   // one cycle per resynced rising edge
    logic pps_valid;  // last interval within tolerance
  } pps_status_t;

endpackage

// ==== logic/nco_ctrl_if.sv ====
// NCO control link between the phase corrector and the NCO
// increment and align going in, SYNC strobe and count coming back
`timescale 1ns/100ps

interface nco_ctrl_if;
  import sync_cfg_pkg::*;
  import sync_stat_pkg::*;

  phase_t      incr;        // phase increment, held between corrections
  logic        align;       // one-cycle strobe, zero the phase
  logic        sync_pulse;  // one cycle per wrap or align
  sync_count_t sync_count;  // running pulse count

  // corrector side
  modport ctrl (
    output incr,
    output align,
    input  sync_pulse,
    input  sync_count
  );

  // accumulator side
  modport nco (
    input  incr,
    input  align,
    output sync_pulse,
    output sync_count
  );

endinterface

// ==== logic/pps_monitor.sv ====
// PPS input monitor
// resyncs the PPS pin, strobes each rising edge and flags whether
// the time since the previous edge lies inside the tolerance window
`timescale 1ns/100ps

module pps_monitor #(
  parameter int unsigned clk_hz  = sync_cfg_pkg::default_clk_hz,
  parameter int unsigned sync_hz = sync_cfg_pkg::default_sync_hz,
  parameter int unsigned pps_n   = sync_cfg_pkg::default_pps_n,
  parameter int unsigned pps_s   = sync_cfg_pkg::default_pps_s,
  parameter int unsigned tol_us  = sync_cfg_pkg::default_tol_us
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       pps,
  output sync_stat_pkg::pps_status_t status
);
  import sync_cfg_pkg::*;

  localparam longint unsigned clk_hz_l      = clk_hz;
  localparam longint unsigned period_cycles = clk_hz_l * pps_s / pps_n;
  localparam longint unsigned tol_raw       = clk_hz_l * tol_us / 1_000_000;
  // never wider than half a sample, else realign would pick the wrong sample
  localparam longint unsigned half_sync     = clk_hz_l / sync_hz / 2;
  localparam longint unsigned tol_cycles    = (tol_raw < half_sync) ? tol_raw : half_sync;
  localparam longint unsigned win_lo        = period_cycles - tol_cycles;
  localparam longint unsigned win_hi        = period_cycles + tol_cycles;

  logic [1:0]                sync_q;     // two-flop synchronizer
  logic                      pps_d;      // delayed copy for edge detect
  logic                      edge_q;     // registered rising edge
  logic                      valid_q;
  logic                      seen_q;     // an edge since reset
  logic [interval_cnt_w-1:0] interval_q; // cycles since last edge
  logic                      in_window;

  assign in_window = (interval_q >= win_lo) && (interval_q <= win_hi);

  // resync and edge detect, edge_q rises 3 cycles after the pin
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync_q <= '0;
      pps_d  <= 1'b0;
      edge_q <= 1'b0;
    end
    else
    begin
      sync_q <= {sync_q[0], pps};
      pps_d  <= sync_q[1];
      edge_q <= sync_q[1] & ~pps_d;
    end
  end

  // interval measurement, judged at each edge
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      interval_q <= '0;
      seen_q     <= 1'b0;
      valid_q    <= 1'b0;
    end
    else if (edge_q)
    begin
      valid_q    <= seen_q & in_window; // first edge has nothing to compare to
      seen_q     <= 1'b1;
      interval_q <= interval_cnt_w'(1); // edge cycle counts as one
    end
    else if (interval_q != '1)
    begin
      interval_q <= interval_q + 1'b1;  // saturate when PPS is lost
    end
  end

  assign status.pps_edge  = edge_q;
  assign status.pps_valid = valid_q;

endmodule

// ==== logic/sync_nco.sv ====
// SYNC pulse NCO
// phase accumulator whose carry gives the sensor sample strobe,
// zeroed by align, plus a running count of pulses for the LEDs
`timescale 1ns/100ps

module sync_nco #(
  parameter int unsigned clk_hz  = sync_cfg_pkg::default_clk_hz,
  parameter int unsigned sync_hz = sync_cfg_pkg::default_sync_hz,
  parameter int unsigned pps_n   = sync_cfg_pkg::default_pps_n,
  parameter int unsigned pps_s   = sync_cfg_pkg::default_pps_s
) (
  input logic     clk,
  input logic     rst_n,
  nco_ctrl_if.nco ctl
);
  import sync_cfg_pkg::*;
  import sync_stat_pkg::*;

  localparam longint unsigned period_cycles   = longint'(clk_hz) * pps_s / pps_n;
  localparam longint unsigned expected_pulses = longint'(sync_hz) * pps_s / pps_n;
  // pulses per PPS interval over cycles per interval, rounded
  localparam phase_t nom_incr =
    phase_t'(((64'd1 << phase_w) * expected_pulses + period_cycles / 2) / period_cycles);

  phase_t      phase_q;
  phase_t      incr_q;      // local copy, eases timing across the link
  phase_t      phase_next;
  logic        carry;
  logic        pulse_next;
  logic        pulse_q;
  sync_count_t count_q;

  assign {carry, phase_next} = {1'b0, phase_q} + {1'b0, incr_q};
  assign pulse_next          = ctl.align | carry; // align forces a pulse

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase_q <= '0;
      incr_q  <= nom_incr;
      pulse_q <= 1'b0;
      count_q <= '0;
    end
    else
    begin
      incr_q  <= ctl.incr;
      phase_q <= ctl.align ? '0 : phase_next; // re-phase on valid PPS
      pulse_q <= pulse_next;
      if (pulse_next)
        count_q <= count_q + 1'b1; // moves together with the pulse
    end
  end

  assign ctl.sync_pulse = pulse_q;
  assign ctl.sync_count = count_q;

endmodule

// ==== logic/phase_corrector.sv ====
// PPS phase and frequency corrector
// counts SYNC pulses per PPS interval and steps the NCO increment
// toward the nominal rate, with manual faster/slower nudges
`timescale 1ns/100ps

module phase_corrector #(
  parameter int unsigned clk_hz    = sync_cfg_pkg::default_clk_hz,
  parameter int unsigned sync_hz   = sync_cfg_pkg::default_sync_hz,
  parameter int unsigned pps_n     = sync_cfg_pkg::default_pps_n,
  parameter int unsigned pps_s     = sync_cfg_pkg::default_pps_s,
  parameter int unsigned corr_step = sync_cfg_pkg::default_corr_step
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  sync_stat_pkg::pps_status_t status,
  input  logic                       faster,
  input  logic                       slower,
  nco_ctrl_if.ctrl                   ctl
);
  import sync_cfg_pkg::*;

  localparam longint unsigned period_cycles   = longint'(clk_hz) * pps_s / pps_n;
  localparam longint unsigned expected_pulses = longint'(sync_hz) * pps_s / pps_n;
  localparam longint unsigned half_sync       = longint'(clk_hz) / sync_hz / 2;
  localparam phase_t nom_incr =
    phase_t'(((64'd1 << phase_w) * expected_pulses + period_cycles / 2) / period_cycles);
  localparam phase_t auto_step   = phase_t'(corr_step);
  localparam phase_t manual_step = phase_t'(corr_step * 64);

  logic [1:0]                faster_q;    // button synchronizers
  logic [1:0]                slower_q;
  logic [interval_cnt_w-1:0] interval_q;  // own edge-to-edge cycle count
  logic [interval_cnt_w-1:0] pulse_cnt_q; // SYNC pulses this interval
  logic                      seen_q;
  logic                      interval_ok_q; // previous interval realigned
  logic                      cur_ok;
  logic                      align_q;
  phase_t                    incr_q;
  phase_t                    incr_next;

  // realign only when the edge is within half a sample of nominal
  assign cur_ok = seen_q && (interval_q >= period_cycles - half_sync)
                         && (interval_q <= period_cycles + half_sync);

  // frequency step from last interval's pulse count
  always_comb
  begin
    incr_next = incr_q;
    if (pulse_cnt_q < expected_pulses)
      incr_next = incr_next + auto_step;   // too few pulses, speed up
    else if (pulse_cnt_q > expected_pulses)
      incr_next = incr_next - auto_step;
    if (faster_q[1])
      incr_next = incr_next + manual_step;
    if (slower_q[1])
      incr_next = incr_next - manual_step;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      faster_q <= '0;
      slower_q <= '0;
    end
    else
    begin
      faster_q <= {faster_q[0], faster};
      slower_q <= {slower_q[0], slower};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      interval_q    <= '0;
      pulse_cnt_q   <= '0;
      seen_q        <= 1'b0;
      interval_ok_q <= 1'b0;
      align_q       <= 1'b0;
      incr_q        <= nom_incr;
    end
    else if (status.pps_edge)
    begin
      align_q       <= cur_ok;
      interval_ok_q <= cur_ok;
      // count only means something if the interval started with an align
      if (cur_ok && interval_ok_q)
        incr_q <= incr_next;
      seen_q      <= 1'b1;
      interval_q  <= interval_cnt_w'(1);
      pulse_cnt_q <= '0; // align pulse lands in the next interval
    end
    else
    begin
      align_q <= 1'b0;
      if (ctl.sync_pulse)
        pulse_cnt_q <= pulse_cnt_q + 1'b1;
      if (interval_q != '1)
        interval_q <= interval_q + 1'b1; // saturates without PPS
    end
  end

  assign ctl.incr  = incr_q;
  assign ctl.align = align_q;

endmodule

// ==== logic/adxl355_sync_top.sv ====
// ADXL355 sample clock generator, top level
// PPS monitor, phase corrector and SYNC NCO joined by the NCO control link
`timescale 1ns/100ps

module adxl355_sync_top #(
  parameter int unsigned clk_hz    = sync_cfg_pkg::default_clk_hz,
  parameter int unsigned sync_hz   = sync_cfg_pkg::default_sync_hz,
  parameter int unsigned pps_n     = sync_cfg_pkg::default_pps_n,
  parameter int unsigned pps_s     = sync_cfg_pkg::default_pps_s,
  parameter int unsigned tol_us    = sync_cfg_pkg::default_tol_us,
  parameter int unsigned corr_step = sync_cfg_pkg::default_corr_step
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       pps,       // rising edge marks the second
  input  logic                       faster,    // manual nudge up
  input  logic                       slower,    // manual nudge down
  output logic                       sync_out,  // ADXL355 SYNC pin
  output logic                       pps_valid,
  output sync_stat_pkg::sync_count_t led
);

  sync_stat_pkg::pps_status_t pps_status;

  nco_ctrl_if nco_ctl ();

  pps_monitor #(
    .clk_hz  (clk_hz),
    .sync_hz (sync_hz),
    .pps_n   (pps_n),
    .pps_s   (pps_s),
    .tol_us  (tol_us)
  ) u_pps_monitor (
    .clk    (clk),
    .rst_n  (rst_n),
    .pps    (pps),
    .status (pps_status)
  );

  phase_corrector #(
    .clk_hz    (clk_hz),
    .sync_hz   (sync_hz),
    .pps_n     (pps_n),
    .pps_s     (pps_s),
    .corr_step (corr_step)
  ) u_phase_corrector (
    .clk    (clk),
    .rst_n  (rst_n),
    .status (pps_status),
    .faster (faster),
    .slower (slower),
    .ctl    (nco_ctl.ctrl)
  );

  sync_nco #(
    .clk_hz  (clk_hz),
    .sync_hz (sync_hz),
    .pps_n   (pps_n),
    .pps_s   (pps_s)
  ) u_sync_nco (
    .clk   (clk),
    .rst_n (rst_n),
    .ctl   (nco_ctl.nco)
  );

  assign sync_out  = nco_ctl.sync_pulse;
  assign led       = nco_ctl.sync_count; // pulse count on the LEDs
  assign pps_valid = pps_status.pps_valid;

endmodule

// ==== verification/adxl355_sync_tb.sv ====
// testbench for the ADXL355 sample clock generator
// drives PPS with nominal and skewed periods plus manual nudges,
// checks validity, realignment, SYNC spacing, LED count and steering
`timescale 1ns/100ps

module adxl355_sync_tb;

  localparam int unsigned clk_hz        = 10000;
  localparam int unsigned sync_hz       = 100;
  localparam int unsigned tol_us        = 1000;
  localparam int unsigned corr_step     = 4096;  // large enough that nudges show in spacing
  localparam int          period_cycles = 10000; // one PPS second
  localparam int          tol_cycles    = 10;
  localparam int          sync_spacing  = 100;   // clk_hz / sync_hz
  localparam int          pps_high      = 1000;
  localparam int          reset_cycles  = 16;
  localparam int          valid_delay   = 4;     // pps rise to pps_valid
  localparam int          align_delay   = 5;     // pps rise to sync_out
  localparam int          n_periods     = 12;
  localparam int          max_cycles    = n_periods * period_cycles * 11 / 10;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       pps;
  logic       faster;
  logic       slower;
  logic       sync_out;
  logic       pps_valid;
  logic [7:0] led;

  integer seed;
  int     off_in;
  int     off_out;
  int     mode;            // 0 nominal, 1 faster, 2 slower, 3 unchecked
  int     cyc;
  int     rise_cyc;
  int     interval;
  int     last_pulse_cyc;
  int     spacing;
  int     pulses_between;  // sync pulses since the last rise
  int     sync_seen;
  bit     have_rise;
  bit     have_pulse;
  bit     last_align;
  bit     is_align;
  bit     cur_valid;
  bit     prev_valid;
  bit     pps_prev;
  bit     out_of_reset;
  bit     saw_short;
  bit     saw_long;
  bit     converged;
  int     err_reset;
  int     err_valid;
  int     err_align;
  int     err_spacing;
  int     err_led;
  int     err_steer;
  int     err_conv;
  int     err_total;

  adxl355_sync_top #(
    .clk_hz    (clk_hz),
    .sync_hz   (sync_hz),
    .pps_n     (1),
    .pps_s     (1),
    .tol_us    (tol_us),
    .corr_step (corr_step)
  ) u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .pps       (pps),
    .faster    (faster),
    .slower    (slower),
    .sync_out  (sync_out),
    .pps_valid (pps_valid),
    .led       (led)
  );

  always #20 clk = ~clk; // 40 ns period

  // cycle count and run limit
  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (cyc >= max_cycles)
    begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // one PPS period, rise first, nudge levels change mid-period
  task automatic run_pps_period(input int offset, input int new_mode,
                                input logic fast_lvl, input logic slow_lvl);
    int len;
    int i;
    len = period_cycles + offset;
    @(posedge clk);
    pps <= 1'b1;
    for (i = 1; i < len; i++)
    begin
      @(posedge clk);
      if (i == pps_high)
        pps <= 1'b0;
      if (i == 10)
        mode = new_mode; // after the align pulse
      if (i == len / 2)
      begin
        faster <= fast_lvl; // held across the next rise
        slower <= slow_lvl;
      end
    end
  endtask

  // all checks sample at the falling edge, outputs settled
  always @(negedge clk)
  begin
    if (!rst_n || !out_of_reset)
    begin
      assert (sync_out == 1'b0) else
      begin
        err_reset++;
        $display("error reset_sync_out: expected 0, actual %0d", sync_out);
      end
      assert (pps_valid == 1'b0) else
      begin
        err_reset++;
        $display("error reset_pps_valid: expected 0, actual %0d", pps_valid);
      end
      assert (led == 8'd0) else
      begin
        err_reset++;
        $display("error reset_led: expected 0, actual %0d", led);
      end
      if (rst_n)
        out_of_reset = 1'b1; // first cycle after release checked too
    end
    else
    begin
      if (pps && !pps_prev)
      begin
        interval  = cyc - rise_cyc;
        cur_valid = have_rise && (interval >= period_cycles - tol_cycles)
                              && (interval <= period_cycles + tol_cycles);
        if (mode == 3 && cur_valid && prev_valid &&
            pulses_between >= sync_hz - 1 && pulses_between <= sync_hz + 1)
          converged = 1'b1;
        prev_valid     = cur_valid;
        pulses_between = 0;
        rise_cyc       = cyc;
        have_rise      = 1'b1;
      end
      if (have_rise && cyc == rise_cyc + valid_delay)
      begin
        assert (pps_valid == cur_valid) else
        begin
          err_valid++;
          $display("error pps_valid: expected %0d, actual %0d", cur_valid, pps_valid);
        end
      end
      if (have_rise && cur_valid && cyc == rise_cyc + align_delay)
      begin
        assert (sync_out == 1'b1) else
        begin
          err_align++;
          $display("error align_sync_out: expected 1, actual %0d", sync_out);
        end
      end
      if (sync_out)
      begin
        sync_seen++;
        pulses_between++;
        is_align = have_rise && (cyc == rise_cyc + align_delay);
        if (have_pulse && !is_align && !last_align)
        begin
          spacing = cyc - last_pulse_cyc;
          case (mode)
            0:
            begin
              assert (spacing >= sync_spacing - 1 && spacing <= sync_spacing + 1) else
              begin
                err_spacing++;
                $display("error spacing: expected %0d, actual %0d", sync_spacing, spacing);
              end
            end
            1:
            begin
              assert (spacing <= sync_spacing) else
              begin
                err_steer++;
                $display("error faster_spacing: expected %0d, actual %0d",
                         sync_spacing, spacing);
              end
              if (spacing < sync_spacing)
                saw_short = 1'b1;
            end
            2:
            begin
              assert (spacing >= sync_spacing) else
              begin
                err_steer++;
                $display("error slower_spacing: expected %0d, actual %0d",
                         sync_spacing, spacing);
              end
              if (spacing > sync_spacing)
                saw_long = 1'b1;
            end
            default: ;
          endcase
        end
        last_pulse_cyc = cyc;
        last_align     = is_align;
        have_pulse     = 1'b1;
      end
      assert (led == sync_seen[7:0]) else
      begin
        err_led++;
        $display("error led_count: expected %0d, actual %0d", sync_seen[7:0], led);
      end
    end
    pps_prev = pps;
  end

  initial
  begin
    seed      = 32'hf5f5_a7ad;
    rst_n     = 1'b0;
    pps       = 1'b0;
    faster    = 1'b0;
    slower    = 1'b0;
    mode      = 0;
    cyc       = 0;
    rise_cyc  = 0;
    sync_seen = 0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    repeat (20) @(posedge clk);
    off_in  = $random(seed) % 9;                       // inside tolerance
    off_out = 21 + ($unsigned($random(seed)) % 10);    // well outside
    if ($random(seed) & 1)
      off_out = -off_out;
    run_pps_period(0, 0, 1'b0, 1'b0);        // first rise, never valid
    run_pps_period(off_in, 0, 1'b0, 1'b0);
    run_pps_period(off_out, 0, 1'b0, 1'b0);  // next rise invalid
    run_pps_period(0, 0, 1'b1, 1'b0);        // faster across the next rise
    run_pps_period(0, 1, 1'b0, 1'b1);
    run_pps_period(0, 3, 1'b0, 1'b1);        // slower across two rises
    run_pps_period(0, 2, 1'b0, 1'b0);
    run_pps_period(0, 3, 1'b0, 1'b0);
    run_pps_period(0, 3, 1'b0, 1'b0);
    @(posedge clk);
    pps <= 1'b1;                             // closing rise
    repeat (20) @(posedge clk);
    pps <= 1'b0;
    repeat (5) @(posedge clk);
    assert (saw_short) else
    begin
      err_steer++;
      $display("holding faster never shortened the SYNC spacing");
    end
    assert (saw_long) else
    begin
      err_steer++;
      $display("holding slower never lengthened the SYNC spacing");
    end
    assert (converged) else
    begin
      err_conv++;
      $display("pulse count per PPS second did not return near nominal");
    end
    err_total = err_reset + err_valid + err_align + err_spacing + err_led
              + err_steer + err_conv;
    $display("errors: reset %0d, validity %0d, alignment %0d, spacing %0d, ",
             err_reset, err_valid, err_align, err_spacing,
             "led %0d, steering %0d, convergence %0d, total %0d",
             err_led, err_steer, err_conv, err_total);
    if (err_total == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== adxl355_sync_top.f ====
logic/sync_cfg_pkg.sv
logic/sync_stat_pkg.sv
logic/nco_ctrl_if.sv
logic/pps_monitor.sv
logic/sync_nco.sv
logic/phase_corrector.sv
logic/adxl355_sync_top.sv
verification/adxl355_sync_tb.sv

// ==== Bender.yml ====
package:
  name: adxl355_sync

sources:
  - files:
      - logic/sync_cfg_pkg.sv
      - logic/sync_stat_pkg.sv
      - logic/nco_ctrl_if.sv
      - logic/pps_monitor.sv
      - logic/sync_nco.sv
      - logic/phase_corrector.sv
      - logic/adxl355_sync_top.sv
  - target: test
    files:
      - verification/adxl355_sync_tb.sv
